//--- Bender.yml
package:
  name: soc_top

export_include_dirs:
  - include

sources:
  - files:
      - rtl/soc_pkg.sv
      - rtl/jtag_tap.sv
      - rtl/dbg_wb_master.sv
      - rtl/wb_intercon.sv
      - rtl/wb_ram.sv
      - rtl/uart_regs.sv
      - rtl/uart_tx.sv
      - rtl/soc_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/soc_tb.sv

//--- bench/jtag_driver.svh
`ifndef JTAG_DRIVER_SVH
`define JTAG_DRIVER_SVH

////////////////////
// TAP pin drivers
////////////////////

// One TCK period, TDO sampled just before the rising edge
task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
	tck = 1'b0;
	tms = tms_v;
	tdi = tdi_v;
	repeat (8) @(negedge wb_clk);
	tdo_v = tdo;
	tck = 1'b1;
	repeat (8) @(negedge wb_clk);
endtask

// Five TMS highs reach Test-Logic-Reset from anywhere, then go idle
task automatic tap_reset();
	logic tdo_v;
	repeat (5) tck_cycle(1'b1, 1'b0, tdo_v);
	tck_cycle(1'b0, 1'b0, tdo_v);
endtask

// Run-Test/Idle to Run-Test/Idle through the IR column
task automatic shift_ir(input logic [`SOC_IR_W-1:0] ir);
	logic tdo_v;
	int i;
	tck_cycle(1'b1, 1'b0, tdo_v);
	tck_cycle(1'b1, 1'b0, tdo_v);
	tck_cycle(1'b0, 1'b0, tdo_v);
	tck_cycle(1'b0, 1'b0, tdo_v);
	for (i = 0; i < `SOC_IR_W; i++)
		tck_cycle(i == `SOC_IR_W - 1, ir[i], tdo_v);
	tck_cycle(1'b1, 1'b0, tdo_v);
	tck_cycle(1'b0, 1'b0, tdo_v);
endtask

// Shifts n bits LSB first, bit i of dout is TDO seen with bit i of din
task automatic shift_dr(input logic [`SOC_DR_W-1:0] din, input int n,
		output logic [`SOC_DR_W-1:0] dout);
	logic tdo_v;
	int i;
	dout = '0;
	tck_cycle(1'b1, 1'b0, tdo_v);
	tck_cycle(1'b0, 1'b0, tdo_v);
	tck_cycle(1'b0, 1'b0, tdo_v);
	for (i = 0; i < n; i++) begin
		tck_cycle(i == n - 1, din[i], tdo_v);
		dout[i] = tdo_v;
	end
	tck_cycle(1'b1, 1'b0, tdo_v);
	tck_cycle(1'b0, 1'b0, tdo_v);
endtask

////////////////////
// UART receiver
////////////////////

// Samples each bit in its middle
task automatic recv_frame(input int bit_clks, output logic [7:0] rx);
	int waited;
	int i;
	waited = 0;
	while (uart_tx !== 1'b0 && waited < 4 * scan_clks) begin
		@(negedge wb_clk);
		waited++;
	end
	if (uart_tx !== 1'b0)
		stop_run("No UART start bit appeared on the TX pad in time");
	repeat (bit_clks / 2) @(negedge wb_clk);
	check("start bit", uart_tx, 1'b0);
	for (i = 0; i < 8; i++) begin
		repeat (bit_clks) @(negedge wb_clk);
		rx[i] = uart_tx;
	end
	repeat (bit_clks) @(negedge wb_clk);
	check("stop bit", uart_tx, 1'b1);
endtask

`endif

//--- bench/soc_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module soc_tb;

	localparam int tck_clks = 16;
	localparam int scan_tcks = 80;
	localparam int scan_clks = scan_tcks * tck_clks;
	localparam int n_scans = 130;
	localparam int uart_div = 799;
	localparam int n_frames = 2;
	// Twice the expected run length, in wb clocks
	localparam int limit_clks = 2 * (n_scans * scan_clks + n_frames * 14 * (uart_div + 1));
	// Read of RAM word 0, loaded while polling
	localparam logic [`SOC_DR_W-1:0] poll_cmd = {1'b0, 4'hF, 32'h0, 32'h0};

	logic wb_clk, reset, tck, tms, tdi;
	wire tdo, uart_tx, irq;

	// Reference model state
	logic [31:0] ram_m [`SOC_RAM_WORDS];
	logic [15:0] div_m;
	logic en_m, pend_m, busy_m;

	soc_top dut_i (
		.wb_clk_i      (wb_clk),
		.reset_i       (reset),
		.tck_pad_i     (tck),
		.tms_pad_i     (tms),
		.tdi_pad_i     (tdi),
		.tdo_pad_o     (tdo),
		.uart_tx_pad_o (uart_tx),
		.irq_o         (irq)
	);

	`include "jtag_driver.svh"

	always #10 wb_clk = ~wb_clk;

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("** Error at time %0t: %s got %h, expected %h",
				$time, what, got, exp));
	endtask

	// Expected {done, err, dat} of one bus access, updates the model
	function automatic logic [33:0] ref_access(input logic we, input logic [3:0] sel,
			input logic [31:0] adr, input logic [31:0] dat);
		logic [31:0] rd;
		logic err;
		int idx;
		int b;
		rd = '0;
		err = 1'b0;
		if (adr >= `SOC_RAM_BASE && adr < `SOC_RAM_BASE + `SOC_RAM_WORDS * 4) begin
			idx = (adr - `SOC_RAM_BASE) >> 2;
			rd = ram_m[idx];
			if (we)
				for (b = 0; b < 4; b++)
					if (sel[b])
						ram_m[idx][b*8 +: 8] = dat[b*8 +: 8];
		end else if (adr >= `SOC_UART_BASE && adr < `SOC_UART_BASE + `SOC_UART_SIZE) begin
			case (adr[3:2])
			2'd0: if (we && !busy_m) busy_m = 1'b1;
			2'd1: begin
				rd = {30'd0, pend_m, busy_m};
				if (we && dat[1])
					pend_m = 1'b0;
			end
			2'd2: begin
				rd = {16'd0, div_m};
				if (we)
					div_m = dat[15:0];
			end
			default: begin
				rd = {31'd0, en_m};
				if (we)
					en_m = dat[0];
			end
			endcase
		end else
			err = 1'b1;
		return {1'b1, err, rd};
	endfunction

	// End of a frame as the model sees it
	task automatic note_frame_sent();
		busy_m = 1'b0;
		pend_m = 1'b1;
	endtask

	// One debug command, then poll until done
	task automatic run_cmd(input logic we, input logic [3:0] sel, input logic [31:0] adr,
			input logic [31:0] dat, input string what);
		logic [33:0] exp_r;
		logic [`SOC_DR_W-1:0] dout;
		int polls;
		exp_r = ref_access(we, sel, adr, dat);
		shift_dr({we, sel, adr, dat}, `SOC_DR_W, dout);
		polls = 0;
		do begin
			shift_dr(poll_cmd, `SOC_DR_W, dout);
			polls++;
		end while (!dout[68] && polls < 4);
		check({what, " done"}, dout[68], exp_r[33]);
		check({what, " err"}, dout[67], exp_r[32]);
		if (!we)
			check({what, " data"}, dout[31:0], exp_r[31:0]);
	endtask

	initial begin
		#(limit_clks * 20);
		stop_run("Watchdog expired before the test sequence finished");
	end

	initial begin
		logic [`SOC_DR_W-1:0] dout;
		logic [31:0] adr;
		logic [31:0] addr_q [$];
		logic [7:0] pat, rx, tx_b;
		logic [3:0] sel;
		int unsigned seed;
		int waited;
		seed = $urandom(32'h6f5a);
		wb_clk = 1'b0;
		reset = 1'b1;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		div_m = 16'd3;
		en_m = 1'b0;
		pend_m = 1'b0;
		busy_m = 1'b0;
		repeat (3) @(negedge wb_clk);
		reset = 1'b0;

		////////////////////
		// TAP registers
		////////////////////
		tap_reset();
		shift_dr('0, 32, dout);
		check("idcode", dout[31:0], `SOC_IDCODE);
		shift_ir(`SOC_IR_BYPASS);
		pat = $urandom;
		shift_dr(`SOC_DR_W'(pat), 9, dout);
		// One bit of delay, captured zero first
		check("bypass", dout[8:0], {pat, 1'b0});
		shift_ir(`SOC_IR_DEBUG);

		////////////////////
		// RAM through the debug master
		////////////////////
		repeat (8) begin
			adr = ($urandom % `SOC_RAM_WORDS) * 4;
			addr_q.push_back(adr);
			run_cmd(1'b1, 4'hF, adr, $urandom, "ram write");
		end
		foreach (addr_q[i])
			run_cmd(1'b0, 4'hF, addr_q[i], '0, "ram read");

		// Byte lanes
		repeat (8) begin
			adr = ($urandom % `SOC_RAM_WORDS) * 4;
			sel = $urandom;
			run_cmd(1'b1, 4'hF, adr, $urandom, "full write");
			run_cmd(1'b1, sel, adr, $urandom, "lane write");
			run_cmd(1'b0, 4'hF, adr, '0, "lane read");
		end

		// Holes in the map, one aliases a RAM word
		run_cmd(1'b1, 4'hF, addr_q[0] | 32'h1000, $urandom, "hole write");
		run_cmd(1'b0, 4'hF, addr_q[0], '0, "ram after hole");
		run_cmd(1'b0, 4'hF, `SOC_UART_BASE + 32'h10, '0, "hole read");

		////////////////////
		// UART and irq
		////////////////////
		run_cmd(1'b1, 4'hF, `SOC_UART_BASE + 32'h8, uart_div, "divisor write");
		run_cmd(1'b0, 4'hF, `SOC_UART_BASE + 32'h8, '0, "divisor read");
		run_cmd(1'b1, 4'hF, `SOC_UART_BASE + 32'hC, 32'h1, "irq enable");
		tx_b = $urandom;
		fork
			recv_frame(uart_div + 1, rx);
			begin
				run_cmd(1'b1, 4'hF, `SOC_UART_BASE, tx_b, "txdata");
				run_cmd(1'b0, 4'hF, `SOC_UART_BASE + 32'h4, '0, "status busy");
			end
		join
		check("uart byte", rx, tx_b);
		note_frame_sent();
		waited = 0;
		while (irq !== 1'b1 && waited < 2 * (uart_div + 1)) begin
			@(negedge wb_clk);
			waited++;
		end
		check("irq set", irq, 1'b1);
		run_cmd(1'b0, 4'hF, `SOC_UART_BASE + 32'h4, '0, "status pending");
		run_cmd(1'b1, 4'hF, `SOC_UART_BASE + 32'h4, 32'h2, "irq clear");
		check("irq cleared", irq, 1'b0);

		// Masked interrupt
		run_cmd(1'b1, 4'hF, `SOC_UART_BASE + 32'hC, 32'h0, "irq disable");
		tx_b = $urandom;
		fork
			recv_frame(uart_div + 1, rx);
			run_cmd(1'b1, 4'hF, `SOC_UART_BASE, tx_b, "txdata masked");
		join
		check("uart byte masked", rx, tx_b);
		repeat (2 * (uart_div + 1)) begin
			@(negedge wb_clk);
			check("irq masked", irq, 1'b0);
		end
		note_frame_sent();
		run_cmd(1'b0, 4'hF, `SOC_UART_BASE + 32'h4, '0, "status masked");

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- include/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Wishbone bus widths
`define SOC_DW 32
`define SOC_AW 32

// Address map
`define SOC_RAM_WORDS 1024
`define SOC_RAM_BASE  32'h0000_0000
`define SOC_UART_BASE 32'h9000_0000
`define SOC_UART_SIZE 32'h0000_0010

// JTAG instruction codes and device ID
`define SOC_IR_W      4
`define SOC_IR_IDCODE 4'h2
`define SOC_IR_DEBUG  4'h8
`define SOC_IR_BYPASS 4'hF
`define SOC_IDCODE    32'h1000_0A5D

// Debug data register length
`define SOC_DR_W 69

`endif

//--- rtl/dbg_wb_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module dbg_wb_master (
	input  wire                   wb_clk_i,
	input  wire                   reset_i,
	input  wire                   tck_rise_i,
	input  wire                   tdi_i,
	input  wire                   capture_dr_i,
	input  wire                   shift_dr_i,
	input  wire                   update_dr_i,
	output logic                  tdo_o,
	output soc_pkg::wb_m2s_t      wb_o,
	input  wire soc_pkg::wb_s2m_t wb_i
);

	soc_pkg::dbg_dr_u dr_q;
	soc_pkg::dbg_rsp_t rsp_q;

	// Data register, LSB goes out first
	always_ff @(posedge wb_clk_i) begin
		if (tck_rise_i) begin
			if (capture_dr_i)
				dr_q.rsp <= rsp_q;
			else if (shift_dr_i)
				dr_q <= {tdi_i, dr_q[`SOC_DR_W-1:1]};
		end
	end

	assign tdo_o = dr_q[0];

	////////////////////
	// Bus cycle
	////////////////////
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			wb_o.cyc <= 1'b0;
			wb_o.stb <= 1'b0;
			rsp_q <= '0;
		end else if (wb_o.cyc) begin
			// Cycle ends on ack or err, response kept for the next capture
			if (wb_i.ack || wb_i.err) begin
				wb_o.cyc <= 1'b0;
				wb_o.stb <= 1'b0;
				rsp_q.done <= 1'b1;
				rsp_q.err <= wb_i.err;
				rsp_q.dat <= wb_i.dat;
			end
		end else if (tck_rise_i && update_dr_i) begin
			wb_o.adr <= dr_q.cmd.adr;
			wb_o.dat <= dr_q.cmd.dat;
			wb_o.sel <= dr_q.cmd.sel;
			wb_o.we <= dr_q.cmd.we;
			wb_o.cyc <= 1'b1;
			wb_o.stb <= 1'b1;
			rsp_q.done <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/jtag_tap.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module jtag_tap (
	input  wire  wb_clk_i,
	input  wire  reset_i,
	input  wire  tck_pad_i,
	input  wire  tms_pad_i,
	input  wire  tdi_pad_i,
	output logic tdo_pad_o,
	input  wire  dbg_tdo_i,
	output logic tck_rise_o,
	output logic tck_fall_o,
	output logic tdi_o,
	output logic debug_select_o,
	output logic capture_dr_o,
	output logic shift_dr_o,
	output logic update_dr_o
);

	localparam logic [3:0] st_tlr     = 4'd0;
	localparam logic [3:0] st_rti     = 4'd1;
	localparam logic [3:0] st_sel_dr  = 4'd2;
	localparam logic [3:0] st_cap_dr  = 4'd3;
	localparam logic [3:0] st_sh_dr   = 4'd4;
	localparam logic [3:0] st_ex1_dr  = 4'd5;
	localparam logic [3:0] st_pau_dr  = 4'd6;
	localparam logic [3:0] st_ex2_dr  = 4'd7;
	localparam logic [3:0] st_upd_dr  = 4'd8;
	localparam logic [3:0] st_sel_ir  = 4'd9;
	localparam logic [3:0] st_cap_ir  = 4'd10;
	localparam logic [3:0] st_sh_ir   = 4'd11;
	localparam logic [3:0] st_ex1_ir  = 4'd12;
	localparam logic [3:0] st_pau_ir  = 4'd13;
	localparam logic [3:0] st_ex2_ir  = 4'd14;
	localparam logic [3:0] st_upd_ir  = 4'd15;

	logic [1:0] tck_s, tms_s, tdi_s;
	logic tck_q;
	logic [3:0] state_q, state_d;
	logic [`SOC_IR_W-1:0] ir_q, ir_sr;
	logic [31:0] id_sr;
	logic bypass_q;

	////////////////////
	// Pad synchronizers
	////////////////////
	always_ff @(posedge wb_clk_i) begin
		tck_s <= {tck_s[0], tck_pad_i};
		tms_s <= {tms_s[0], tms_pad_i};
		tdi_s <= {tdi_s[0], tdi_pad_i};
		tck_q <= tck_s[1];
	end

	assign tck_rise_o = tck_s[1] & ~tck_q;
	assign tck_fall_o = ~tck_s[1] & tck_q;
	assign tdi_o = tdi_s[1];

	// Standard 16-state TAP controller, TMS sampled on TCK rise
	always_comb begin
		case (state_q)
		st_tlr:    state_d = tms_s[1] ? st_tlr    : st_rti;
		st_rti:    state_d = tms_s[1] ? st_sel_dr : st_rti;
		st_sel_dr: state_d = tms_s[1] ? st_sel_ir : st_cap_dr;
		st_cap_dr: state_d = tms_s[1] ? st_ex1_dr : st_sh_dr;
		st_sh_dr:  state_d = tms_s[1] ? st_ex1_dr : st_sh_dr;
		st_ex1_dr: state_d = tms_s[1] ? st_upd_dr : st_pau_dr;
		st_pau_dr: state_d = tms_s[1] ? st_ex2_dr : st_pau_dr;
		st_ex2_dr: state_d = tms_s[1] ? st_upd_dr : st_sh_dr;
		st_upd_dr: state_d = tms_s[1] ? st_sel_dr : st_rti;
		st_sel_ir: state_d = tms_s[1] ? st_tlr    : st_cap_ir;
		st_cap_ir: state_d = tms_s[1] ? st_ex1_ir : st_sh_ir;
		st_sh_ir:  state_d = tms_s[1] ? st_ex1_ir : st_sh_ir;
		st_ex1_ir: state_d = tms_s[1] ? st_upd_ir : st_pau_ir;
		st_pau_ir: state_d = tms_s[1] ? st_ex2_ir : st_pau_ir;
		st_ex2_ir: state_d = tms_s[1] ? st_upd_ir : st_sh_ir;
		default:   state_d = tms_s[1] ? st_sel_dr : st_rti;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			state_q <= st_tlr;
			ir_q <= `SOC_IR_IDCODE;
		end else if (tck_rise_o) begin
			state_q <= state_d;
			if (state_q == st_tlr)
				ir_q <= `SOC_IR_IDCODE;
			else if (state_q == st_upd_ir)
				ir_q <= ir_sr;
		end
	end

	// Local shift registers for IR, IDCODE and BYPASS
	always_ff @(posedge wb_clk_i) begin
		if (tck_rise_o) begin
			case (state_q)
			st_cap_ir: ir_sr <= `SOC_IR_W'(1);
			st_sh_ir:  ir_sr <= {tdi_o, ir_sr[`SOC_IR_W-1:1]};
			st_cap_dr: begin
				id_sr <= `SOC_IDCODE;
				bypass_q <= 1'b0;
			end
			st_sh_dr: begin
				id_sr <= {tdi_o, id_sr[31:1]};
				bypass_q <= tdi_o;
			end
			default: ;
			endcase
		end
	end

	assign debug_select_o = (ir_q == `SOC_IR_DEBUG);
	assign capture_dr_o = tck_rise_o & debug_select_o & (state_q == st_cap_dr);
	assign shift_dr_o = tck_rise_o & debug_select_o & (state_q == st_sh_dr);
	assign update_dr_o = tck_rise_o & debug_select_o & (state_q == st_upd_dr);

	// TDO launched on the falling TCK edge
	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			tdo_pad_o <= 1'b0;
		else if (tck_fall_o) begin
			if (state_q == st_sh_ir)
				tdo_pad_o <= ir_sr[0];
			else if (state_q == st_sh_dr) begin
				case (ir_q)
				`SOC_IR_IDCODE: tdo_pad_o <= id_sr[0];
				`SOC_IR_DEBUG:  tdo_pad_o <= dbg_tdo_i;
				default:        tdo_pad_o <= bypass_q;
				endcase
			end else
				tdo_pad_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/soc_pkg.sv
`default_nettype none
`include "soc_consts.svh"

package soc_pkg;

	// Master to slave
	typedef struct packed {
		logic [`SOC_AW-1:0]   adr;
		logic [`SOC_DW-1:0]   dat;
		logic [`SOC_DW/8-1:0] sel;
		logic                 we;
		logic                 cyc;
		logic                 stb;
	} wb_m2s_t;

	// Slave to master
	typedef struct packed {
		logic [`SOC_DW-1:0] dat;
		logic               ack;
		logic               err;
	} wb_s2m_t;

	// Command as seen after Update-DR, data ends up at the LSB end
	typedef struct packed {
		logic                 we;
		logic [`SOC_DW/8-1:0] sel;
		logic [`SOC_AW-1:0]   adr;
		logic [`SOC_DW-1:0]   dat;
	} dbg_cmd_t;

	// Status loaded at Capture-DR
	typedef struct packed {
		logic                         done;
		logic                         err;
		logic [`SOC_DR_W-`SOC_DW-3:0] pad;
		logic [`SOC_DW-1:0]           dat;
	} dbg_rsp_t;

	typedef union packed {
		dbg_cmd_t cmd;
		dbg_rsp_t rsp;
	} dbg_dr_u;

endpackage

`default_nettype wire

//--- rtl/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
	input  wire  wb_clk_i,
	input  wire  reset_i,
	input  wire  tck_pad_i,
	input  wire  tms_pad_i,
	input  wire  tdi_pad_i,
	output logic tdo_pad_o,
	output logic uart_tx_pad_o,
	output logic irq_o
);

	logic tck_rise, tdi, capture_dr, shift_dr, update_dr, dbg_tdo;
	soc_pkg::wb_m2s_t dbg_m2s, ram_m2s, uart_m2s;
	soc_pkg::wb_s2m_t dbg_s2m, ram_s2m, uart_s2m;
	logic [7:0] tx_byte;
	logic [15:0] divisor;
	logic tx_start, tx_busy, tx_done;

	////////////////////
	// JTAG and debug
	////////////////////
	jtag_tap jtag_tap0 (
		.wb_clk_i       (wb_clk_i),
		.reset_i        (reset_i),
		.tck_pad_i      (tck_pad_i),
		.tms_pad_i      (tms_pad_i),
		.tdi_pad_i      (tdi_pad_i),
		.tdo_pad_o      (tdo_pad_o),
		.dbg_tdo_i      (dbg_tdo),
		.tck_rise_o     (tck_rise),
		.tck_fall_o     (),
		.tdi_o          (tdi),
		.debug_select_o (),
		.capture_dr_o   (capture_dr),
		.shift_dr_o     (shift_dr),
		.update_dr_o    (update_dr)
	);

	dbg_wb_master dbg_if0 (
		.wb_clk_i     (wb_clk_i),
		.reset_i      (reset_i),
		.tck_rise_i   (tck_rise),
		.tdi_i        (tdi),
		.capture_dr_i (capture_dr),
		.shift_dr_i   (shift_dr),
		.update_dr_i  (update_dr),
		.tdo_o        (dbg_tdo),
		.wb_o         (dbg_m2s),
		.wb_i         (dbg_s2m)
	);

	////////////////////
	// Bus and slaves
	////////////////////
	wb_intercon intercon0 (
		.wb_clk_i (wb_clk_i),
		.reset_i  (reset_i),
		.m_i      (dbg_m2s),
		.m_o      (dbg_s2m),
		.ram_o    (ram_m2s),
		.ram_i    (ram_s2m),
		.uart_o   (uart_m2s),
		.uart_i   (uart_s2m)
	);

	wb_ram ram0 (
		.wb_clk_i (wb_clk_i),
		.reset_i  (reset_i),
		.wb_i     (ram_m2s),
		.wb_o     (ram_s2m)
	);

	// UART registers beside the transmitter
	uart_regs uart_regs0 (
		.wb_clk_i   (wb_clk_i),
		.reset_i    (reset_i),
		.wb_i       (uart_m2s),
		.wb_o       (uart_s2m),
		.tx_byte_o  (tx_byte),
		.tx_start_o (tx_start),
		.divisor_o  (divisor),
		.tx_busy_i  (tx_busy),
		.tx_done_i  (tx_done),
		.irq_o      (irq_o)
	);

	uart_tx uart_tx0 (
		.wb_clk_i   (wb_clk_i),
		.reset_i    (reset_i),
		.tx_byte_i  (tx_byte),
		.tx_start_i (tx_start),
		.divisor_i  (divisor),
		.busy_o     (tx_busy),
		.done_o     (tx_done),
		.tx_o       (uart_tx_pad_o)
	);

endmodule

`default_nettype wire

//--- rtl/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module uart_regs (
	input  wire                   wb_clk_i,
	input  wire                   reset_i,
	input  wire soc_pkg::wb_m2s_t wb_i,
	output soc_pkg::wb_s2m_t      wb_o,
	output logic [7:0]            tx_byte_o,
	output logic                  tx_start_o,
	output logic [15:0]           divisor_o,
	input  wire                   tx_busy_i,
	input  wire                   tx_done_i,
	output logic                  irq_o
);

	logic access, wr, busy;
	logic ack_q, irq_en_q, irq_pend_q;
	logic [`SOC_DW-1:0] rd_val, rdat_q;

	assign access = wb_i.cyc & wb_i.stb & ~ack_q;
	assign wr = access & wb_i.we;
	// Busy already in the start cycle
	assign busy = tx_busy_i | tx_start_o;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			tx_start_o <= 1'b0;
			divisor_o <= 16'd3;
			irq_en_q <= 1'b0;
			irq_pend_q <= 1'b0;
		end else begin
			ack_q <= access;
			tx_start_o <= wr && wb_i.adr[3:2] == 2'd0 && !busy;
			if (wr && wb_i.adr[3:2] == 2'd2)
				divisor_o <= wb_i.dat[15:0];
			if (wr && wb_i.adr[3:2] == 2'd3)
				irq_en_q <= wb_i.dat[0];
			// Set wins over a clear in the same cycle
			if (tx_done_i)
				irq_pend_q <= 1'b1;
			else if (wr && wb_i.adr[3:2] == 2'd1 && wb_i.dat[1])
				irq_pend_q <= 1'b0;
		end
	end

	always_comb begin
		rd_val = '0;
		case (wb_i.adr[3:2])
		2'd1: rd_val[1:0] = {irq_pend_q, busy};
		2'd2: rd_val[15:0] = divisor_o;
		2'd3: rd_val[0] = irq_en_q;
		default: ;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (wr && wb_i.adr[3:2] == 2'd0 && !busy)
			tx_byte_o <= wb_i.dat[7:0];
		if (access)
			rdat_q <= rd_val;
	end

	assign wb_o = '{dat: rdat_q, ack: ack_q, err: 1'b0};
	assign irq_o = irq_pend_q & irq_en_q;

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  wire        wb_clk_i,
	input  wire        reset_i,
	input  wire [7:0]  tx_byte_i,
	input  wire        tx_start_i,
	input  wire [15:0] divisor_i,
	output logic       busy_o,
	output logic       done_o,
	output logic       tx_o
);

	logic [9:0] sh_q;
	logic [15:0] baud_q;
	logic [3:0] bit_q;

	// Frame is stop, data LSB first, start, shifted out from bit 0
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			sh_q <= '1;
			busy_o <= 1'b0;
			done_o <= 1'b0;
			baud_q <= '0;
			bit_q <= '0;
		end else begin
			done_o <= 1'b0;
			if (!busy_o) begin
				if (tx_start_i) begin
					sh_q <= {1'b1, tx_byte_i, 1'b0};
					baud_q <= divisor_i;
					bit_q <= 4'd9;
					busy_o <= 1'b1;
				end
			end else if (baud_q != 16'd0)
				baud_q <= baud_q - 16'd1;
			else if (bit_q == 4'd0) begin
				// End of stop bit
				busy_o <= 1'b0;
				done_o <= 1'b1;
			end else begin
				sh_q <= {1'b1, sh_q[9:1]};
				bit_q <= bit_q - 4'd1;
				baud_q <= divisor_i;
			end
		end
	end

	assign tx_o = sh_q[0];

endmodule

`default_nettype wire

//--- rtl/wb_intercon.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module wb_intercon (
	input  wire                   wb_clk_i,
	input  wire                   reset_i,
	input  wire soc_pkg::wb_m2s_t m_i,
	output soc_pkg::wb_s2m_t      m_o,
	output soc_pkg::wb_m2s_t      ram_o,
	input  wire soc_pkg::wb_s2m_t ram_i,
	output soc_pkg::wb_m2s_t      uart_o,
	input  wire soc_pkg::wb_s2m_t uart_i
);

	localparam logic [`SOC_AW-1:0] ram_span = `SOC_RAM_WORDS * 4;
	localparam logic [`SOC_AW-1:0] uart_mask = ~(`SOC_UART_SIZE - 1);

	logic ram_hit, uart_hit;
	logic err_q;

	// Address decode
	assign ram_hit = (m_i.adr - `SOC_RAM_BASE) < ram_span;
	assign uart_hit = (m_i.adr & uart_mask) == `SOC_UART_BASE;

	always_comb begin
		ram_o = m_i;
		ram_o.stb = m_i.stb & ram_hit;
		uart_o = m_i;
		uart_o.stb = m_i.stb & uart_hit;
		if (ram_hit)
			m_o = ram_i;
		else if (uart_hit)
			m_o = uart_i;
		else
			m_o = '{dat: '0, ack: 1'b0, err: err_q};
	end

	// Error for holes in the map, one cycle after stb
	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			err_q <= 1'b0;
		else
			err_q <= m_i.cyc & m_i.stb & ~ram_hit & ~uart_hit & ~err_q;
	end

endmodule

`default_nettype wire

//--- rtl/wb_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_consts.svh"

module wb_ram (
	input  wire                   wb_clk_i,
	input  wire                   reset_i,
	input  wire soc_pkg::wb_m2s_t wb_i,
	output soc_pkg::wb_s2m_t      wb_o
);

	localparam int idx_w = $clog2(`SOC_RAM_WORDS);

	logic [`SOC_DW-1:0] mem [`SOC_RAM_WORDS];
	logic [`SOC_DW-1:0] dat_q;
	logic [idx_w-1:0] idx;
	logic access, ack_q;

	assign idx = wb_i.adr[idx_w+1:2];
	assign access = wb_i.cyc & wb_i.stb & ~ack_q;

	// Byte lanes written under sel
	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			if (wb_i.we) begin
				for (int b = 0; b < `SOC_DW/8; b++)
					if (wb_i.sel[b])
						mem[idx][b*8 +: 8] <= wb_i.dat[b*8 +: 8];
			end
			dat_q <= mem[idx];
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	assign wb_o = '{dat: dat_q, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

//--- soc_top.f
+incdir+include
+incdir+bench
rtl/soc_pkg.sv
rtl/jtag_tap.sv
rtl/dbg_wb_master.sv
rtl/wb_intercon.sv
rtl/wb_ram.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/soc_top.sv
bench/soc_tb.sv
